// ==== scene_pkg.sv ====
`default_nettype none

package scene_pkg;

    // Property word and instruction field widths
    localparam int DATA_WIDTH      = 16;
    localparam int FIELD_SEL_WIDTH = 3;
    localparam int INDEX_WIDTH     = 4;    // Covers the deepest memory

    // Fields per record kind
    localparam int CAMERA_FIELDS = 4;
    localparam int LIGHT_FIELDS  = 4;
    localparam int SHAPE_FIELDS  = 6;

    // Memory depths
    localparam int NUM_LIGHTS = 4;
    localparam int NUM_SHAPES = 16;

    localparam int LIGHT_ADDR_WIDTH = $clog2(NUM_LIGHTS);
    localparam int SHAPE_ADDR_WIDTH = $clog2(NUM_SHAPES);

    // Flat record widths, used by the field merge
    localparam int CAMERA_WIDTH = CAMERA_FIELDS * DATA_WIDTH;
    localparam int LIGHT_WIDTH  = LIGHT_FIELDS * DATA_WIDTH;
    localparam int SHAPE_WIDTH  = SHAPE_FIELDS * DATA_WIDTH;

    typedef logic [LIGHT_ADDR_WIDTH-1:0] light_addr_t;
    typedef logic [SHAPE_ADDR_WIDTH-1:0] shape_addr_t;

    // Field 0 is the least significant word of each record
    typedef logic [CAMERA_FIELDS-1:0][DATA_WIDTH-1:0] camera_t;
    typedef logic [LIGHT_FIELDS-1:0][DATA_WIDTH-1:0]  light_t;
    typedef logic [SHAPE_FIELDS-1:0][DATA_WIDTH-1:0]  shape_t;

    typedef enum logic [2:0] {
        op_nop        = 3'd0,
        op_camera_set = 3'd1,
        op_light_set  = 3'd2,
        op_shape_set  = 3'd3,
        op_frame      = 3'd4    // Hands the bank over to the renderer
    } scene_op_t;

endpackage

`default_nettype wire

// ==== scene_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module scene_ram #(
    parameter type entry_t = logic [15:0],
    parameter int  DEPTH   = 4
) (
    input  wire                                      clk_100mhz,
    input  wire                                      we,
    input  wire [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0]  addr_a,
    input  wire entry_t                              wdata_a,
    output entry_t                                   rdata_a,
    input  wire [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0]  addr_b,
    output entry_t                                   rdata_b
);

    entry_t                                 mem [DEPTH];
    logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0] addr_q;   // Address of the record read last cycle

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Port A: the write lands on the record fetched in the previous cycle,
    // so a read-modify-write never blocks the next read
    always_ff @(posedge clk_100mhz) begin
        if (we) begin
            mem[addr_q] <= wdata_a;
        end
        rdata_a <= mem[addr_a];     // Read-first
        addr_q  <= addr_a;
    end

    // Port B, render side
    always_ff @(posedge clk_100mhz) begin
        rdata_b <= mem[addr_b];
    end

    write_in_range: assert property (@(posedge clk_100mhz) we |-> (addr_q < DEPTH));

endmodule

`default_nettype wire

// ==== bank_mode_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module bank_mode_fsm (
    input  wire                   clk_100mhz,
    input  wire                   rst,
    input  wire                   inst_valid,
    input  wire scene_pkg::scene_op_t inst_op,
    input  wire                   controller_busy,
    output logic                  stall,
    output logic                  inst_accept
);

    typedef enum logic [1:0] {
        st_writing,
        st_render_pending,     // Frame taken, renderer not started yet
        st_render_busy
    } mode_state_t;

    mode_state_t state;
    mode_state_t state_next;

    assign stall       = (state != st_writing);
    assign inst_accept = inst_valid && !stall;

    always_comb begin
        state_next = state;
        case (state)
            st_writing: begin
                if (inst_accept && inst_op == scene_pkg::op_frame) begin
                    state_next = st_render_pending;
                end
            end
            st_render_pending: begin
                if (controller_busy) begin
                    state_next = st_render_busy;
                end
            end
            st_render_busy: begin
                if (!controller_busy) begin
                    state_next = st_writing;    // Stall drops next cycle
                end
            end
            default: state_next = st_writing;
        endcase
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state <= st_writing;
        end else begin
            state <= state_next;
        end
    end

    // The renderer must have gone idle before the bank is released
    stall_release: assert property (@(posedge clk_100mhz) disable iff (rst)
        $fell(stall) |-> !$past(controller_busy));

endmodule

`default_nettype wire

// ==== scene_update_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module scene_update_pipe (
    input  wire                                  clk_100mhz,
    input  wire                                  rst,
    input  wire                                  inst_accept,
    input  wire scene_pkg::scene_op_t            inst_op,
    input  wire [scene_pkg::INDEX_WIDTH-1:0]     inst_index,
    input  wire [scene_pkg::FIELD_SEL_WIDTH-1:0] inst_field,
    input  wire [scene_pkg::DATA_WIDTH-1:0]      inst_data,
    output logic                                 camera_we,
    output scene_pkg::camera_t                   camera_wdata,
    input  wire scene_pkg::camera_t              camera_rdata,
    output logic                                 light_we,
    output scene_pkg::light_addr_t               light_addr,
    output scene_pkg::light_t                    light_wdata,
    input  wire scene_pkg::light_t               light_rdata,
    output logic                                 shape_we,
    output scene_pkg::shape_addr_t               shape_addr,
    output scene_pkg::shape_t                    shape_wdata,
    input  wire scene_pkg::shape_t               shape_rdata
);

    // Stage 1 registers
    logic                                 s1_valid;
    scene_pkg::scene_op_t                 s1_op;
    logic [scene_pkg::INDEX_WIDTH-1:0]    s1_index;
    logic [scene_pkg::FIELD_SEL_WIDTH-1:0] s1_field;
    logic [scene_pkg::DATA_WIDTH-1:0]     s1_data;

    // Last written record
    logic                                 fwd_valid;
    scene_pkg::scene_op_t                 fwd_op;
    logic [scene_pkg::INDEX_WIDTH-1:0]    fwd_index;
    scene_pkg::camera_t                   fwd_camera;
    scene_pkg::light_t                    fwd_light;
    scene_pkg::shape_t                    fwd_shape;

    logic                                 camera_hit;
    logic                                 light_hit;
    logic                                 shape_hit;
    scene_pkg::camera_t                   camera_base;
    scene_pkg::light_t                    light_base;
    scene_pkg::shape_t                    shape_base;
    logic [scene_pkg::SHAPE_WIDTH-1:0]    camera_wide;
    logic [scene_pkg::SHAPE_WIDTH-1:0]    light_wide;

    // Replaces one field; selectors past the kind's field count change nothing
    function automatic logic [scene_pkg::SHAPE_WIDTH-1:0] merge_field(
        input logic [scene_pkg::SHAPE_WIDTH-1:0]     rec,
        input logic [scene_pkg::FIELD_SEL_WIDTH-1:0] field,
        input int                                    num_fields,
        input logic [scene_pkg::DATA_WIDTH-1:0]      data
    );
        logic [scene_pkg::SHAPE_WIDTH-1:0] merged;
        merged = rec;
        for (int i = 0; i < scene_pkg::SHAPE_FIELDS; i++) begin
            if (i < num_fields && field == i) begin
                merged[i*scene_pkg::DATA_WIDTH +: scene_pkg::DATA_WIDTH] = data;
            end
        end
        return merged;
    endfunction

    // Read addresses go straight out in the accept cycle
    assign light_addr = inst_index[scene_pkg::LIGHT_ADDR_WIDTH-1:0];
    assign shape_addr = inst_index[scene_pkg::SHAPE_ADDR_WIDTH-1:0];

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            s1_valid  <= inst_accept;
            fwd_valid <= camera_we | light_we | shape_we;   // One cycle deep only
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (inst_accept) begin
            s1_op    <= inst_op;
            s1_index <= inst_index;
            s1_field <= inst_field;
            s1_data  <= inst_data;
        end
        if (camera_we | light_we | shape_we) begin
            fwd_op    <= s1_op;
            fwd_index <= s1_index;
        end
        if (camera_we) begin
            fwd_camera <= camera_wdata;
        end
        if (light_we) begin
            fwd_light <= light_wdata;
        end
        if (shape_we) begin
            fwd_shape <= shape_wdata;
        end
    end

    // Back-to-back hit on the same record: memory data is one write behind
    assign camera_hit = fwd_valid && fwd_op == scene_pkg::op_camera_set;
    assign light_hit  = fwd_valid && fwd_op == scene_pkg::op_light_set &&
                        fwd_index[scene_pkg::LIGHT_ADDR_WIDTH-1:0] ==
                        s1_index[scene_pkg::LIGHT_ADDR_WIDTH-1:0];
    assign shape_hit  = fwd_valid && fwd_op == scene_pkg::op_shape_set &&
                        fwd_index[scene_pkg::SHAPE_ADDR_WIDTH-1:0] ==
                        s1_index[scene_pkg::SHAPE_ADDR_WIDTH-1:0];

    assign camera_base = camera_hit ? fwd_camera : camera_rdata;
    assign light_base  = light_hit ? fwd_light : light_rdata;
    assign shape_base  = shape_hit ? fwd_shape : shape_rdata;

    // Stage 2 merge, zero padded up to the widest record
    assign camera_wide = merge_field(
        {{(scene_pkg::SHAPE_WIDTH - scene_pkg::CAMERA_WIDTH){1'b0}}, camera_base},
        s1_field, scene_pkg::CAMERA_FIELDS, s1_data);
    assign light_wide = merge_field(
        {{(scene_pkg::SHAPE_WIDTH - scene_pkg::LIGHT_WIDTH){1'b0}}, light_base},
        s1_field, scene_pkg::LIGHT_FIELDS, s1_data);

    assign camera_wdata = camera_wide[scene_pkg::CAMERA_WIDTH-1:0];
    assign light_wdata  = light_wide[scene_pkg::LIGHT_WIDTH-1:0];
    assign shape_wdata  = merge_field(shape_base, s1_field, scene_pkg::SHAPE_FIELDS, s1_data);

    // Nop and frame write nothing
    assign camera_we = s1_valid && s1_op == scene_pkg::op_camera_set;
    assign light_we  = s1_valid && s1_op == scene_pkg::op_light_set;
    assign shape_we  = s1_valid && s1_op == scene_pkg::op_shape_set;

    single_write: assert property (@(posedge clk_100mhz) disable iff (rst)
        $onehot0({camera_we, light_we, shape_we}));

endmodule

`default_nettype wire

// ==== scene_memory_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module scene_memory_bank (
    input  wire                                  clk_100mhz,
    input  wire                                  rst,
    input  wire                                  controller_busy,
    input  wire                                  inst_valid,
    input  wire scene_pkg::scene_op_t            inst_op,
    input  wire [scene_pkg::INDEX_WIDTH-1:0]     inst_index,
    input  wire [scene_pkg::FIELD_SEL_WIDTH-1:0] inst_field,
    input  wire [scene_pkg::DATA_WIDTH-1:0]      inst_data,
    output logic                                 stall,
    input  wire scene_pkg::light_addr_t          light_read_addr,
    input  wire scene_pkg::shape_addr_t          shape_read_addr,
    output scene_pkg::camera_t                   camera_out,
    output scene_pkg::light_t                    light_out,
    output scene_pkg::shape_t                    shape_out
);

    logic                   inst_accept;
    logic                   camera_we;
    scene_pkg::camera_t     camera_wdata;
    scene_pkg::camera_t     camera_rdata;
    logic                   light_we;
    scene_pkg::light_addr_t light_addr;
    scene_pkg::light_t      light_wdata;
    scene_pkg::light_t      light_rdata;
    logic                   shape_we;
    scene_pkg::shape_addr_t shape_addr;
    scene_pkg::shape_t      shape_wdata;
    scene_pkg::shape_t      shape_rdata;

    bank_mode_fsm i_mode_fsm (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .inst_valid      (inst_valid),
        .inst_op         (inst_op),
        .controller_busy (controller_busy),
        .stall           (stall),
        .inst_accept     (inst_accept)
    );

    scene_update_pipe i_update_pipe (
        .clk_100mhz   (clk_100mhz),
        .rst          (rst),
        .inst_accept  (inst_accept),
        .inst_op      (inst_op),
        .inst_index   (inst_index),
        .inst_field   (inst_field),
        .inst_data    (inst_data),
        .camera_we    (camera_we),
        .camera_wdata (camera_wdata),
        .camera_rdata (camera_rdata),
        .light_we     (light_we),
        .light_addr   (light_addr),
        .light_wdata  (light_wdata),
        .light_rdata  (light_rdata),
        .shape_we     (shape_we),
        .shape_addr   (shape_addr),
        .shape_wdata  (shape_wdata),
        .shape_rdata  (shape_rdata)
    );

    scene_ram #(.entry_t(scene_pkg::camera_t), .DEPTH(1)) i_camera_ram (
        .clk_100mhz (clk_100mhz),
        .we         (camera_we),
        .addr_a     (1'b0),        // Single camera record
        .wdata_a    (camera_wdata),
        .rdata_a    (camera_rdata),
        .addr_b     (1'b0),
        .rdata_b    (camera_out)
    );

    scene_ram #(.entry_t(scene_pkg::light_t), .DEPTH(scene_pkg::NUM_LIGHTS)) i_light_ram (
        .clk_100mhz (clk_100mhz),
        .we         (light_we),
        .addr_a     (light_addr),
        .wdata_a    (light_wdata),
        .rdata_a    (light_rdata),
        .addr_b     (light_read_addr),
        .rdata_b    (light_out)
    );

    scene_ram #(.entry_t(scene_pkg::shape_t), .DEPTH(scene_pkg::NUM_SHAPES)) i_shape_ram (
        .clk_100mhz (clk_100mhz),
        .we         (shape_we),
        .addr_a     (shape_addr),
        .wdata_a    (shape_wdata),
        .rdata_a    (shape_rdata),
        .addr_b     (shape_read_addr),
        .rdata_b    (shape_out)
    );

endmodule

`default_nettype wire

// ==== tb_scene_memory_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_scene_memory_bank;

    localparam int MAX_CYCLES = 4000;   // Tests need about 400 cycles, ten times margin
    localparam int REC_W      = scene_pkg::SHAPE_WIDTH;

    logic                                  clk_100mhz;
    logic                                  rst;
    logic                                  controller_busy;
    logic                                  inst_valid;
    scene_pkg::scene_op_t                  inst_op;
    logic [scene_pkg::INDEX_WIDTH-1:0]     inst_index;
    logic [scene_pkg::FIELD_SEL_WIDTH-1:0] inst_field;
    logic [scene_pkg::DATA_WIDTH-1:0]      inst_data;
    logic                                  stall;
    scene_pkg::light_addr_t                light_read_addr;
    scene_pkg::shape_addr_t                shape_read_addr;
    scene_pkg::camera_t                    camera_out;
    scene_pkg::light_t                     light_out;
    scene_pkg::shape_t                     shape_out;

    // Scoreboard of expected records
    scene_pkg::camera_t exp_camera;
    scene_pkg::light_t  exp_light [scene_pkg::NUM_LIGHTS];
    scene_pkg::shape_t  exp_shape [scene_pkg::NUM_SHAPES];

    int cycle_count;
    int error_count;
    int check_count;
    int test_count;
    int failed_tests;
    int test_start_errors;

    scene_memory_bank i_dut (
        .clk_100mhz      (clk_100mhz),
        .rst             (rst),
        .controller_busy (controller_busy),
        .inst_valid      (inst_valid),
        .inst_op         (inst_op),
        .inst_index      (inst_index),
        .inst_field      (inst_field),
        .inst_data       (inst_data),
        .stall           (stall),
        .light_read_addr (light_read_addr),
        .shape_read_addr (shape_read_addr),
        .camera_out      (camera_out),
        .light_out       (light_out),
        .shape_out       (shape_out)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    always @(posedge clk_100mhz) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // Expected record after writing one field; unknown selectors keep the record
    function automatic logic [REC_W-1:0] ref_merge(
        input logic [REC_W-1:0]               rec,
        input int                             sel,
        input int                             num_fields,
        input logic [scene_pkg::DATA_WIDTH-1:0] data
    );
        logic [REC_W-1:0] mask;
        logic [REC_W-1:0] wide_data;
        if (sel >= num_fields) begin
            return rec;
        end
        mask = '0;
        mask[scene_pkg::DATA_WIDTH-1:0] = '1;
        mask = mask << (sel * scene_pkg::DATA_WIDTH);
        wide_data = '0;
        wide_data[scene_pkg::DATA_WIDTH-1:0] = data;
        return (rec & ~mask) | (wide_data << (sel * scene_pkg::DATA_WIDTH));
    endfunction

    task automatic check_value(input logic [REC_W-1:0] got, input logic [REC_W-1:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_100mhz);
            #1;
        end
    endtask

    // Drives one instruction and updates the scoreboard once it is taken
    task automatic send(input scene_pkg::scene_op_t op, input int index, input int field,
                        input logic [scene_pkg::DATA_WIDTH-1:0] data);
        logic [REC_W-1:0] merged;
        inst_valid = 1'b1;
        inst_op    = op;
        inst_index = index[scene_pkg::INDEX_WIDTH-1:0];
        inst_field = field[scene_pkg::FIELD_SEL_WIDTH-1:0];
        inst_data  = data;
        while (stall) begin     // Source holds the instruction
            wait_cycles(1);
        end
        wait_cycles(1);         // Taken on this edge
        inst_valid = 1'b0;
        case (op)
            scene_pkg::op_camera_set: begin
                merged = ref_merge(REC_W'(exp_camera), field, scene_pkg::CAMERA_FIELDS, data);
                exp_camera = merged[scene_pkg::CAMERA_WIDTH-1:0];
            end
            scene_pkg::op_light_set: begin
                merged = ref_merge(REC_W'(exp_light[index % scene_pkg::NUM_LIGHTS]), field,
                                   scene_pkg::LIGHT_FIELDS, data);
                exp_light[index % scene_pkg::NUM_LIGHTS] = merged[scene_pkg::LIGHT_WIDTH-1:0];
            end
            scene_pkg::op_shape_set: begin
                merged = ref_merge(exp_shape[index % scene_pkg::NUM_SHAPES], field,
                                   scene_pkg::SHAPE_FIELDS, data);
                exp_shape[index % scene_pkg::NUM_SHAPES] = merged;
            end
            default: ;          // Nop and frame leave the records alone
        endcase
    endtask

    task automatic read_check(input int light_idx, input int shape_idx, input string tag);
        light_read_addr = light_idx[scene_pkg::LIGHT_ADDR_WIDTH-1:0];
        shape_read_addr = shape_idx[scene_pkg::SHAPE_ADDR_WIDTH-1:0];
        wait_cycles(1);
        check_value(camera_out, exp_camera, $sformatf("%s camera", tag));
        check_value(light_out, exp_light[light_idx], $sformatf("%s light %0d", tag, light_idx));
        check_value(shape_out, exp_shape[shape_idx], $sformatf("%s shape %0d", tag, shape_idx));
    endtask

    task automatic read_all(input string tag);
        for (int i = 0; i < scene_pkg::NUM_SHAPES; i++) begin
            read_check(i % scene_pkg::NUM_LIGHTS, i, tag);
        end
    endtask

    // Renderer starts, stays busy, then lets the bank go
    task automatic release_render(input int busy_cycles);
        controller_busy = 1'b1;
        wait_cycles(busy_cycles);
        controller_busy = 1'b0;
        while (stall) begin
            wait_cycles(1);
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count != test_start_errors) begin
            failed_tests++;
            $display("[test %0d] %s: %0d mismatches", test_count, name,
                     error_count - test_start_errors);
        end else begin
            $display("[test %0d] %s: passed", test_count, name);
        end
        test_start_errors = error_count;
    endtask

    initial begin
        logic [scene_pkg::DATA_WIDTH-1:0] held_data;
        void'($urandom(48));
        cycle_count       = 0;
        error_count       = 0;
        check_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        rst               = 1'b1;
        controller_busy   = 1'b0;
        inst_valid        = 1'b0;
        inst_op           = scene_pkg::op_nop;
        inst_index        = '0;
        inst_field        = '0;
        inst_data         = '0;
        light_read_addr   = '0;
        shape_read_addr   = '0;
        exp_camera        = '0;
        for (int i = 0; i < scene_pkg::NUM_LIGHTS; i++) exp_light[i] = '0;
        for (int i = 0; i < scene_pkg::NUM_SHAPES; i++) exp_shape[i] = '0;
        repeat (8) @(posedge clk_100mhz);
        #1;
        rst = 1'b0;

        for (int f = 0; f < scene_pkg::CAMERA_FIELDS; f++) begin
            send(scene_pkg::op_camera_set, 0, f, 16'($urandom));
            wait_cycles(4);
            read_check(0, 0, $sformatf("camera field %0d", f));
        end
        finish_test("camera fields");

        // Four writes to one light on consecutive cycles
        for (int f = 0; f < scene_pkg::LIGHT_FIELDS; f++) begin
            send(scene_pkg::op_light_set, 2, f, 16'(16'ha5a0 + f));
        end
        wait_cycles(4);
        read_check(2, 0, "forwarded light");
        finish_test("back-to-back forwarding");

        for (int n = 0; n < 200; n++) begin
            if ($urandom % 2) begin
                send(scene_pkg::op_light_set, $urandom % scene_pkg::NUM_LIGHTS, $urandom % 8,
                     16'($urandom));
            end else begin
                send(scene_pkg::op_shape_set, $urandom % scene_pkg::NUM_SHAPES, $urandom % 8,
                     16'($urandom));
            end
        end
        wait_cycles(4);
        read_all("random");
        finish_test("random light and shape writes");

        send(scene_pkg::op_frame, 0, 0, '0);
        check_value(stall, 1'b1, "stall after frame");
        held_data = 16'($urandom);
        fork
            send(scene_pkg::op_light_set, 1, 3, held_data);
            begin
                wait_cycles(2);
                read_check(1, 0, "light during stall");
                release_render(2);
            end
        join
        wait_cycles(4);
        read_check(1, 0, "light after release");
        finish_test("instruction held during stall");

        send(scene_pkg::op_frame, 0, 0, '0);
        wait_cycles(2);
        check_value(stall, 1'b1, "stall while pending");
        controller_busy = 1'b1;
        for (int c = 0; c < 3; c++) begin
            wait_cycles(1);
            check_value(stall, 1'b1, "stall while busy");
        end
        controller_busy = 1'b0;
        check_value(stall, 1'b1, "stall as busy falls");
        wait_cycles(1);
        check_value(stall, 1'b0, "stall one cycle after busy");
        send(scene_pkg::op_camera_set, 0, 1, 16'($urandom));
        wait_cycles(4);
        read_check(0, 0, "camera after render");
        finish_test("busy pulse release");

        send(scene_pkg::op_nop, $urandom % 16, $urandom % 8, 16'($urandom));
        send(scene_pkg::op_frame, 5, 2, 16'($urandom));
        release_render(2);
        send(scene_pkg::op_nop, $urandom % 16, $urandom % 8, 16'($urandom));
        wait_cycles(4);
        read_all("after nop and frame");
        finish_test("nop and frame write nothing");

        $display("Tests run: %0d, tests failed: %0d, checks: %0d, mismatches: %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
scene_pkg.sv
scene_ram.sv
bank_mode_fsm.sv
scene_update_pipe.sv
scene_memory_bank.sv
tb_scene_memory_bank.sv
